/* Bender.yml */
package:
  name: exec_cluster

sources:
  - include_dirs:
      - include
    files:
      - hw/exec_pkg.sv
      - hw/barrel_shifter.sv
      - hw/alu_dispatch.sv
      - hw/alu_lane.sv
      - hw/result_collect.sv
      - hw/exec_cluster.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_exec_cluster.sv

/* hw/alu_dispatch.sv */
`timescale 1ns/10ps
`include "exec_cfg.svh"

module alu_dispatch (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    in_valid,     // One strobe per bundle
	input  logic [`EXEC_LANES-1:0]                  in_lane_en,
	input  logic [`EXEC_LANES-1:0][6:0]             in_opcode,
	input  logic [`EXEC_LANES-1:0][2:0]             in_funct3,
	input  logic [`EXEC_LANES-1:0][6:0]             in_funct7,
	input  exec_pkg::word_t [`EXEC_LANES-1:0]       in_a,
	input  exec_pkg::word_t [`EXEC_LANES-1:0]       in_b,         // Immediate already sign-extended
	output logic [`EXEC_LANES-1:0]                  lane_valid,
	output exec_pkg::alu_op_e [`EXEC_LANES-1:0]     lane_op,
	output logic [`EXEC_LANES-1:0]                  lane_word,    // Sign-extend request
	output logic [`EXEC_LANES-1:0]                  lane_illegal,
	output exec_pkg::word_t [`EXEC_LANES-1:0]       lane_a,
	output exec_pkg::word_t [`EXEC_LANES-1:0]       lane_b
);

	exec_pkg::alu_op_e [`EXEC_LANES-1:0] dec_op;
	logic [`EXEC_LANES-1:0]              dec_word;
	logic [`EXEC_LANES-1:0]              dec_illegal;

	// Decode of one lane from opcode, funct3 and funct7
	function automatic void decode_lane(
		input  logic [6:0]        opc,
		input  logic [2:0]        f3,
		input  logic [6:0]        f7,
		output exec_pkg::alu_op_e op,
		output logic              word,
		output logic              illegal
	);
		logic reg_reg; // OP or OP_32, funct7 fully defined
		logic alt;     // funct7 bit 5
		reg_reg = (opc == exec_pkg::OPC_OP) || (opc == exec_pkg::OPC_OP_32);
		alt = f7[5];
		word = (opc == exec_pkg::OPC_OP_32) || (opc == exec_pkg::OPC_OP_IMM_32);
		illegal = 1'b0;

		case (f3)
			3'b000: op = (reg_reg && alt) ? exec_pkg::ALU_SUB : exec_pkg::ALU_ADD; // Immediates never sub
			3'b001: op = exec_pkg::ALU_SLL;
			3'b010: op = exec_pkg::ALU_SLT;
			3'b011: op = exec_pkg::ALU_SLTU;
			3'b100: op = exec_pkg::ALU_XOR;
			3'b101: op = alt ? exec_pkg::ALU_SRA : exec_pkg::ALU_SRL; // Also for srai
			3'b110: op = exec_pkg::ALU_OR;
			default: op = exec_pkg::ALU_AND;
		endcase

		case (opc)
			exec_pkg::OPC_OP, exec_pkg::OPC_OP_IMM: begin
				illegal = 1'b0; // All funct3 defined
			end
			exec_pkg::OPC_OP_32, exec_pkg::OPC_OP_IMM_32: begin
				illegal = !(f3 inside {3'b000, 3'b001, 3'b101}); // Only add, sll, srl/sra
			end
			exec_pkg::OPC_LOAD, exec_pkg::OPC_STORE: begin
				op = exec_pkg::ALU_ADD; // Address generation
			end
			default: begin
				op = exec_pkg::ALU_ADD;
				illegal = 1'b1; // Unknown major opcode
			end
		endcase

		// Register forms allow only 0x00 and 0x20
		if (reg_reg && (f7 != 7'h00) && (f7 != 7'h20))
			illegal = 1'b1;
	endfunction

	always_comb begin
		for (int i = 0; i < `EXEC_LANES; i++)
			decode_lane(in_opcode[i], in_funct3[i], in_funct7[i],
				dec_op[i], dec_word[i], dec_illegal[i]);
	end

	// Control bits, cleared by reset
	always_ff @(posedge clk) begin
		if (rst) begin
			lane_valid   <= '0;
			lane_illegal <= '0;
		end else begin
			lane_valid   <= {`EXEC_LANES{in_valid}} & in_lane_en;
			lane_illegal <= {`EXEC_LANES{in_valid}} & in_lane_en & dec_illegal; // Only live lanes
		end
	end

	// Decoded op and operands
	always_ff @(posedge clk) begin
		lane_op   <= dec_op;
		lane_word <= dec_word;
		lane_a    <= in_a;
		lane_b    <= in_b;
	end

endmodule

/* hw/alu_lane.sv */
`timescale 1ns/10ps
`include "exec_cfg.svh"

module alu_lane (
	input  logic              clk,
	input  logic              rst,
	input  logic              valid,
	input  exec_pkg::alu_op_e op,
	input  logic              word,        // 32-bit form
	input  logic              illegal,     // Carried through to collector
	input  exec_pkg::word_t   a,
	input  exec_pkg::word_t   b,
	output logic              res_valid,
	output logic              res_illegal,
	output exec_pkg::word_t   result,
	output logic              zero,
	output logic              carry,
	output logic              overflow
);

	localparam int MSB = `EXEC_XLEN - 1;

	logic            sub_en;   // Adder in subtract mode
	exec_pkg::word_t b_add;
	exec_pkg::word_t sum;
	logic            sum_c;
	logic            sum_v;
	logic            sh_left;
	logic            sh_arith;
	logic [5:0]      shamt;
	exec_pkg::word_t sh_in;
	exec_pkg::word_t sh_out;
	exec_pkg::word_t raw;
	exec_pkg::word_t res_d;

	assign sub_en = (op == exec_pkg::ALU_SUB) || (op == exec_pkg::ALU_SLT) ||
		(op == exec_pkg::ALU_SLTU);
	assign b_add = b ^ {`EXEC_XLEN{sub_en}}; // Invert b, carry-in below
	assign {sum_c, sum} = {1'b0, a} + {1'b0, b_add} + {{`EXEC_XLEN{1'b0}}, sub_en};
	assign sum_v = (a[MSB] == b_add[MSB]) && (sum[MSB] != a[MSB]);

	assign sh_left  = (op == exec_pkg::ALU_SLL);
	assign sh_arith = (op == exec_pkg::ALU_SRA);
	assign shamt    = word ? {1'b0, b[4:0]} : b[5:0]; // 5-bit amount for word ops

	// Word right shifts see only the low half of a
	always_comb begin
		sh_in = a;
		if (word && !sh_left)
			sh_in = {{(`EXEC_XLEN-32){sh_arith & a[31]}}, a[31:0]};
	end

	barrel_shifter shifter (
		.din   (sh_in),
		.shamt (shamt),
		.left  (sh_left),
		.arith (sh_arith),
		.dout  (sh_out)
	);

	always_comb begin
		case (op)
			exec_pkg::ALU_SLT:  raw = {{MSB{1'b0}}, sum[MSB] ^ sum_v}; // Sign fixed by overflow
			exec_pkg::ALU_SLTU: raw = {{MSB{1'b0}}, ~sum_c};           // Borrow
			exec_pkg::ALU_AND:  raw = a & b;
			exec_pkg::ALU_OR:   raw = a | b;
			exec_pkg::ALU_XOR:  raw = a ^ b;
			exec_pkg::ALU_SLL, exec_pkg::ALU_SRL, exec_pkg::ALU_SRA: raw = sh_out;
			default:            raw = sum; // add, sub, address
		endcase
		res_d = word ? {{(`EXEC_XLEN-32){raw[31]}}, raw[31:0]} : raw;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid   <= 1'b0;
			res_illegal <= 1'b0;
		end else begin
			res_valid   <= valid;
			res_illegal <= illegal;
		end
	end

	always_ff @(posedge clk) begin
		result   <= res_d;
		zero     <= ~|res_d; // On final, extended result
		carry    <= sum_c;
		overflow <= sum_v;
	end

endmodule

/* hw/barrel_shifter.sv */
`timescale 1ns/10ps
`include "exec_cfg.svh"

module barrel_shifter (
	input  exec_pkg::word_t din,
	input  logic [5:0]      shamt,
	input  logic            left,  // 1 = shift left
	input  logic            arith, // Sign fill on right shift
	output exec_pkg::word_t dout
);

	exec_pkg::word_t stage [0:6]; // stage[k] after k mux levels
	logic            fill;

	// Left shift done as right shift of the reversed word
	function automatic exec_pkg::word_t bit_rev(input exec_pkg::word_t x);
		exec_pkg::word_t r;
		for (int i = 0; i < `EXEC_XLEN; i++)
			r[i] = x[`EXEC_XLEN-1-i];
		return r;
	endfunction

	assign fill = arith & ~left & din[`EXEC_XLEN-1];
	assign stage[0] = left ? bit_rev(din) : din;

	// Levels of 1, 2, 4, 8, 16 and 32 positions
	for (genvar k = 0; k < 6; k++) begin : g_level
		localparam int STEP = 1 << k;
		assign stage[k+1] = shamt[k] ?
			{{STEP{fill}}, stage[k][`EXEC_XLEN-1:STEP]} : stage[k];
	end

	assign dout = left ? bit_rev(stage[6]) : stage[6];

endmodule

/* hw/exec_cluster.sv */
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_cluster (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              in_valid,
	input  logic [`EXEC_LANES-1:0]            in_lane_en,
	input  logic [`EXEC_LANES-1:0][6:0]       in_opcode,
	input  logic [`EXEC_LANES-1:0][2:0]       in_funct3,
	input  logic [`EXEC_LANES-1:0][6:0]       in_funct7,
	input  exec_pkg::word_t [`EXEC_LANES-1:0] in_a,
	input  exec_pkg::word_t [`EXEC_LANES-1:0] in_b,
	output logic                              out_valid,   // Three cycles after in_valid
	output logic [`EXEC_LANES-1:0]            out_lane_valid,
	output exec_pkg::word_t [`EXEC_LANES-1:0] out_result,
	output logic [`EXEC_LANES-1:0]            out_zero,
	output logic [`EXEC_LANES-1:0]            out_carry,
	output logic [`EXEC_LANES-1:0]            out_overflow,
	output logic [`EXEC_LANES-1:0]            out_illegal,
	output logic                              out_any_illegal
);

	// Dispatch to lanes
	wire [`EXEC_LANES-1:0]                d_valid;
	wire exec_pkg::alu_op_e [`EXEC_LANES-1:0] d_op;
	wire [`EXEC_LANES-1:0]                d_word;
	wire [`EXEC_LANES-1:0]                d_illegal;
	wire exec_pkg::word_t [`EXEC_LANES-1:0] d_a;
	wire exec_pkg::word_t [`EXEC_LANES-1:0] d_b;

	// Lanes to collector
	wire [`EXEC_LANES-1:0]                l_valid;
	wire [`EXEC_LANES-1:0]                l_illegal;
	wire exec_pkg::word_t [`EXEC_LANES-1:0] l_result;
	wire [`EXEC_LANES-1:0]                l_zero;
	wire [`EXEC_LANES-1:0]                l_carry;
	wire [`EXEC_LANES-1:0]                l_overflow;

	alu_dispatch dispatch (
		.clk(clk), .rst(rst),
		.in_valid(in_valid), .in_lane_en(in_lane_en),
		.in_opcode(in_opcode), .in_funct3(in_funct3), .in_funct7(in_funct7),
		.in_a(in_a), .in_b(in_b),
		.lane_valid(d_valid), .lane_op(d_op), .lane_word(d_word),
		.lane_illegal(d_illegal), .lane_a(d_a), .lane_b(d_b)
	);

	for (genvar i = 0; i < `EXEC_LANES; i++) begin : g_lane
		alu_lane lane (
			.clk(clk), .rst(rst),
			.valid(d_valid[i]), .op(d_op[i]), .word(d_word[i]),
			.illegal(d_illegal[i]), .a(d_a[i]), .b(d_b[i]),
			.res_valid(l_valid[i]), .res_illegal(l_illegal[i]),
			.result(l_result[i]), .zero(l_zero[i]),
			.carry(l_carry[i]), .overflow(l_overflow[i])
		);
	end

	result_collect collect (
		.clk(clk), .rst(rst),
		.lane_valid(l_valid), .lane_illegal(l_illegal), .lane_result(l_result),
		.lane_zero(l_zero), .lane_carry(l_carry), .lane_overflow(l_overflow),
		.out_valid(out_valid), .out_lane_valid(out_lane_valid),
		.out_result(out_result), .out_zero(out_zero), .out_carry(out_carry),
		.out_overflow(out_overflow), .out_illegal(out_illegal),
		.out_any_illegal(out_any_illegal)
	);

endmodule

/* hw/exec_pkg.sv */
`include "exec_cfg.svh"

package exec_pkg;

	typedef logic [`EXEC_XLEN-1:0] word_t; // One operand or result

	// ALU operation selected by dispatch
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
		ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;

	// Major opcodes accepted by the cluster
	typedef enum logic [6:0] {
		OPC_LOAD      = 7'b0000011,
		OPC_OP_IMM    = 7'b0010011,
		OPC_OP_IMM_32 = 7'b0011011, // addiw, slliw, srliw, sraiw
		OPC_STORE     = 7'b0100011,
		OPC_OP        = 7'b0110011,
		OPC_OP_32     = 7'b0111011  // addw, subw, sllw, srlw, sraw
	} opcode_e;

endpackage

/* hw/result_collect.sv */
`timescale 1ns/10ps
`include "exec_cfg.svh"

module result_collect (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [`EXEC_LANES-1:0]            lane_valid,
	input  logic [`EXEC_LANES-1:0]            lane_illegal,
	input  exec_pkg::word_t [`EXEC_LANES-1:0] lane_result,
	input  logic [`EXEC_LANES-1:0]            lane_zero,
	input  logic [`EXEC_LANES-1:0]            lane_carry,
	input  logic [`EXEC_LANES-1:0]            lane_overflow,
	output logic                              out_valid,       // Bundle strobe
	output logic [`EXEC_LANES-1:0]            out_lane_valid,
	output exec_pkg::word_t [`EXEC_LANES-1:0] out_result,
	output logic [`EXEC_LANES-1:0]            out_zero,
	output logic [`EXEC_LANES-1:0]            out_carry,
	output logic [`EXEC_LANES-1:0]            out_overflow,
	output logic [`EXEC_LANES-1:0]            out_illegal,
	output logic                              out_any_illegal
);

	logic [`EXEC_LANES-1:0] bad; // Live and illegal

	assign bad = lane_valid & lane_illegal;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid       <= 1'b0;
			out_lane_valid  <= '0;
			out_illegal     <= '0;
			out_any_illegal <= 1'b0;
		end else begin
			out_valid       <= |lane_valid;
			out_lane_valid  <= lane_valid;
			out_illegal     <= bad;
			out_any_illegal <= |bad;
		end
	end

	// Illegal lanes leave with zero data and flags
	always_ff @(posedge clk) begin
		for (int i = 0; i < `EXEC_LANES; i++) begin
			out_result[i] <= lane_illegal[i] ? '0 : lane_result[i];
		end
		out_zero     <= lane_zero & ~lane_illegal;
		out_carry    <= lane_carry & ~lane_illegal;
		out_overflow <= lane_overflow & ~lane_illegal;
	end

endmodule

/* include/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Lanes per bundle, 1, 2, 4 or 8
`define EXEC_LANES 4

// Datapath width, word ops and 6-bit shamt assume 64
`define EXEC_XLEN 64

`endif

/* project.f */
+incdir+include
hw/exec_pkg.sv
hw/barrel_shifter.sv
hw/alu_dispatch.sv
hw/alu_lane.sv
hw/result_collect.sv
hw/exec_cluster.sv
sim/tb_exec_cluster.sv

/* sim/tb_exec_cluster.sv */
`timescale 1ns/10ps
`include "exec_cfg.svh"

module tb_exec_cluster;

	localparam int L = `EXEC_LANES;

	logic                    clk;
	logic                    rst;
	logic                    in_valid;
	logic [L-1:0]            in_lane_en;
	logic [L-1:0][6:0]       in_opcode;
	logic [L-1:0][2:0]       in_funct3;
	logic [L-1:0][6:0]       in_funct7;
	exec_pkg::word_t [L-1:0] in_a;
	exec_pkg::word_t [L-1:0] in_b;
	logic                    out_valid;
	logic [L-1:0]            out_lane_valid;
	exec_pkg::word_t [L-1:0] out_result;
	logic [L-1:0]            out_zero;
	logic [L-1:0]            out_carry;
	logic [L-1:0]            out_overflow;
	logic [L-1:0]            out_illegal;
	logic                    out_any_illegal;

	logic [6:0]      s_opc [0:L-1]; // Next bundle, per lane
	logic [2:0]      s_f3  [0:L-1];
	logic [6:0]      s_f7  [0:L-1];
	exec_pkg::word_t s_a   [0:L-1];
	exec_pkg::word_t s_b   [0:L-1];
	logic [L-1:0]    s_en;

	exec_pkg::word_t exp_res [0:2][0:L-1]; // Three slots, one per bundle in flight
	logic [L-1:0]    exp_lv  [0:2];
	logic [L-1:0]    exp_ill [0:2];
	logic [L-1:0]    exp_z   [0:2];
	logic [L-1:0]    exp_c   [0:2];
	logic [L-1:0]    exp_v   [0:2];
	logic            exp_any [0:2];

	int seed = 32'h12091d01;
	int err_count = 0;
	int timeout_count = 0;

	exec_cluster UUT (.*);

	always #4 clk = ~clk; // 8 ns period

	function automatic exec_pkg::word_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic exec_pkg::word_t edge_word(input int k);
		case (k % 6)
			0: return 64'h0;
			1: return 64'h1;
			2: return '1;
			3: return 64'h8000_0000_0000_0000; // Most negative
			4: return 64'h7fff_ffff_ffff_ffff;
			default: return 64'h0000_0000_8000_0000;
		endcase
	endfunction

	function automatic logic ref_illegal(input logic [6:0] opc, input logic [2:0] f3,
		input logic [6:0] f7);
		logic f7_bad;
		logic f3_bad; // Word forms know only add, sll, srl and sra
		f7_bad = (f7 != 7'h00) && (f7 != 7'h20);
		f3_bad = (f3 != 3'b000) && (f3 != 3'b001) && (f3 != 3'b101);
		case (opc)
			exec_pkg::OPC_OP: return f7_bad;
			exec_pkg::OPC_OP_32: return f7_bad || f3_bad;
			exec_pkg::OPC_OP_IMM_32: return f3_bad;
			exec_pkg::OPC_OP_IMM, exec_pkg::OPC_LOAD, exec_pkg::OPC_STORE: return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	// Reference model of one lane
	function automatic exec_pkg::word_t ref_result(input logic [6:0] opc, input logic [2:0] f3,
		input logic [6:0] f7, input exec_pkg::word_t a, input exec_pkg::word_t b);
		logic            word;
		logic            reg_reg;
		logic [5:0]      sh;
		logic [31:0]     lo;
		exec_pkg::word_t r;
		word = (opc == exec_pkg::OPC_OP_32) || (opc == exec_pkg::OPC_OP_IMM_32);
		reg_reg = (opc == exec_pkg::OPC_OP) || (opc == exec_pkg::OPC_OP_32);
		sh = word ? {1'b0, b[4:0]} : b[5:0];
		lo = a[31:0];
		if ((opc == exec_pkg::OPC_LOAD) || (opc == exec_pkg::OPC_STORE))
			return a + b; // Address
		case (f3)
			3'b000: r = (reg_reg && f7[5]) ? a - b : a + b;
			3'b001: r = a << sh;
			3'b010: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			3'b011: r = (a < b) ? 64'd1 : 64'd0;
			3'b100: r = a ^ b;
			3'b101: begin
				if (word && f7[5])
					r = {32'h0, $signed(lo) >>> sh};
				else if (word)
					r = {32'h0, lo >> sh};
				else if (f7[5])
					r = $signed(a) >>> sh;
				else
					r = a >> sh;
			end
			3'b110: r = a | b;
			default: r = a & b;
		endcase
		if (word)
			r = {{32{r[31]}}, r[31:0]}; // Sign-extend from bit 31
		return r;
	endfunction

	task automatic check_word(input string name, input exec_pkg::word_t exp,
		input exec_pkg::word_t act);
		if (act !== exp) begin
			err_count++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_count++;
			$display("Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// Kinds 0..9 are 64-bit register ops, 10..18 the word forms
	task automatic set_op(input int l, input int kind, input exec_pkg::word_t a,
		input exec_pkg::word_t b);
		s_opc[l] = (kind < 10) ? exec_pkg::OPC_OP : ((kind < 14) ? exec_pkg::OPC_OP_IMM_32 :
			exec_pkg::OPC_OP_32);
		s_f7[l] = 7'h00;
		case (kind)
			0, 10, 14: s_f3[l] = 3'b000; // add, addiw, addw
			1, 15: begin
				s_f3[l] = 3'b000; // sub, subw
				s_f7[l] = 7'h20;
			end
			2: s_f3[l] = 3'b010;
			3: s_f3[l] = 3'b011;
			4: s_f3[l] = 3'b111;
			5: s_f3[l] = 3'b110;
			6: s_f3[l] = 3'b100;
			7, 11, 16: s_f3[l] = 3'b001; // Left shifts
			8, 12, 17: s_f3[l] = 3'b101;
			default: begin
				s_f3[l] = 3'b101; // sra, sraiw, sraw
				s_f7[l] = 7'h20;
			end
		endcase
		s_a[l] = a;
		s_b[l] = b;
	endtask

	// Drives the bundle and records what must come out of it
	task automatic apply_bundle(input int slot);
		logic            sub;
		logic [64:0]     sum;
		exec_pkg::word_t a;
		exec_pkg::word_t b;
		exec_pkg::word_t res;
		in_valid = 1'b1;
		in_lane_en = s_en;
		for (int l = 0; l < L; l++) begin
			a = s_a[l];
			b = s_b[l];
			in_opcode[l] = s_opc[l];
			in_funct3[l] = s_f3[l];
			in_funct7[l] = s_f7[l];
			in_a[l] = a;
			in_b[l] = b;
			sub = (s_opc[l] != exec_pkg::OPC_LOAD) && (s_opc[l] != exec_pkg::OPC_STORE) &&
				((s_f3[l] == 3'b010) || (s_f3[l] == 3'b011) || ((s_f3[l] == 3'b000) &&
				s_f7[l][5] && ((s_opc[l] == exec_pkg::OPC_OP) || (s_opc[l] == exec_pkg::OPC_OP_32))));
			sum = sub ? {1'b0, a - b} : {1'b0, a} + {1'b0, b};
			exp_c[slot][l] = sub ? (a >= b) : sum[64]; // No borrow in subtract mode
			exp_v[slot][l] = sub ? ((a[63] != b[63]) && (sum[63] != a[63])) :
				((a[63] == b[63]) && (sum[63] != a[63]));
			res = ref_result(s_opc[l], s_f3[l], s_f7[l], a, b);
			exp_lv[slot][l] = s_en[l];
			exp_ill[slot][l] = s_en[l] && ref_illegal(s_opc[l], s_f3[l], s_f7[l]);
			if (exp_ill[slot][l]) begin
				res = '0; // Collector clears illegal lanes
				exp_c[slot][l] = 1'b0;
				exp_v[slot][l] = 1'b0;
			end
			exp_res[slot][l] = res;
			exp_z[slot][l] = (res == '0) && !exp_ill[slot][l];
		end
		exp_any[slot] = |exp_ill[slot];
	endtask

	task automatic check_slot(input string name, input int slot);
		string n;
		check_flag({name, " out_valid"}, 1'b1, out_valid);
		for (int l = 0; l < L; l++) begin
			n = $sformatf("%s lane %0d", name, l);
			check_flag({n, " lane_valid"}, exp_lv[slot][l], out_lane_valid[l]);
			check_flag({n, " illegal"}, exp_ill[slot][l], out_illegal[l]);
			if (exp_lv[slot][l]) begin // Disabled lanes carry no data
				check_word({n, " result"}, exp_res[slot][l], out_result[l]);
				check_flag({n, " zero"}, exp_z[slot][l], out_zero[l]);
				check_flag({n, " carry"}, exp_c[slot][l], out_carry[l]);
				check_flag({n, " overflow"}, exp_v[slot][l], out_overflow[l]);
			end
		end
		check_flag({name, " any_illegal"}, exp_any[slot], out_any_illegal);
	endtask

	// One bundle in, wait for it with a bound of 10 cycles
	task automatic send_bundle(input string name);
		int n;
		@(negedge clk);
		apply_bundle(0);
		@(negedge clk);
		in_valid = 1'b0;
		n = 0;
		while ((out_valid !== 1'b1) && (n < 10)) begin
			@(negedge clk);
			n++;
		end
		if (out_valid === 1'b1)
			check_slot(name, 0);
		else begin
			timeout_count++;
			$display("Timeout in %s: out_valid did not arrive within 10 cycles", name);
		end
	endtask

	task automatic test_reg_reg();
		for (int round = 0; round < 4; round++) begin
			for (int base = 0; base < 10; base += L) begin
				s_en = '1;
				for (int l = 0; l < L; l++) begin
					if (round < 2)
						set_op(l, (base + l) % 10, edge_word(base + l + round),
							edge_word((base + l) * (round + 5) + 1));
					else
						set_op(l, (base + l) % 10, rand_word(), rand_word());
				end
				send_bundle($sformatf("reg_reg round %0d op %0d", round, base));
			end
		end
	endtask

	task automatic test_word_forms();
		for (int round = 0; round < 3; round++) begin
			for (int base = 0; base < 9; base += L) begin
				s_en = '1;
				for (int l = 0; l < L; l++)
					set_op(l, 10 + (base + l) % 9, rand_word() | 64'h8000_0000, // Bit 31 set
						(round == 0) ? (rand_word() | 64'h20) : rand_word()); // Bit 5 ignored
				send_bundle($sformatf("word round %0d op %0d", round, base));
			end
		end
	endtask

	task automatic test_wide_shifts();
		exec_pkg::word_t b;
		for (int base = 0; base < 32; base += L) begin
			s_en = '1;
			for (int l = 0; l < L; l++) begin
				b = rand_word();
				b[5:0] = 6'd32 + 6'((base + l) % 32);
				set_op(l, 7 + (base + l) % 3, rand_word(), b);
				if ((base + l) % 2 == 1)
					s_opc[l] = exec_pkg::OPC_OP_IMM; // slli, srli, srai
			end
			send_bundle($sformatf("wide shift %0d", 32 + base));
		end
		for (int k = 0; k < 2; k++) begin
			for (int l = 0; l < L; l++) begin
				set_op(l, 0, rand_word(), rand_word());
				s_opc[l] = ((l + k) % 2 == 0) ? exec_pkg::OPC_LOAD : exec_pkg::OPC_STORE;
				s_f3[l] = 3'(l + k); // Access width, unused
				s_f7[l] = 7'($random(seed));
			end
			send_bundle($sformatf("load store %0d", k));
		end
	endtask

	task automatic test_illegal();
		for (int shift = 0; shift < 4; shift++) begin
			s_en = '1;
			for (int l = 0; l < L; l++) begin
				set_op(l, 1, rand_word(), rand_word()); // Legal sub by default
				case ((l + shift) % 4)
					0: s_opc[l] = 7'b1111111; // Unknown opcode
					1: s_f7[l] = 7'h01;
					2: begin
						s_opc[l] = exec_pkg::OPC_OP_IMM_32;
						s_f3[l] = 3'b100; // No xoriw
					end
					default: ;
				endcase
			end
			send_bundle($sformatf("illegal pattern %0d", shift));
		end
	endtask

	// Back-to-back bundles, middle one with odd lanes off
	task automatic test_pipeline();
		for (int bn = 0; bn < 3; bn++) begin
			@(negedge clk);
			for (int l = 0; l < L; l++) begin
				set_op(l, (bn * L + l) % 19, rand_word(), rand_word());
				s_en[l] = (bn != 1) || (l % 2 == 0);
			end
			apply_bundle(bn);
		end
		check_flag("pipeline early out_valid", 1'b0, out_valid); // Bundle 0 still in the lanes
		for (int bn = 0; bn < 3; bn++) begin
			@(negedge clk); // Third cycle after entry
			in_valid = 1'b0;
			check_slot($sformatf("pipeline bundle %0d", bn), bn);
		end
		@(negedge clk);
		check_flag("pipeline drain out_valid", 1'b0, out_valid);
	endtask

	task automatic check_reset_idle();
		repeat (5) begin
			@(negedge clk);
			check_flag("reset idle out_valid", 1'b0, out_valid);
			check_flag("reset idle any_illegal", 1'b0, out_any_illegal);
			for (int l = 0; l < L; l++) begin
				check_flag($sformatf("reset idle lane %0d valid", l), 1'b0, out_lane_valid[l]);
				check_flag($sformatf("reset idle lane %0d illegal", l), 1'b0, out_illegal[l]);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_lane_en = '0;
		in_opcode = '0;
		in_funct3 = '0;
		in_funct7 = '0;
		in_a = '0;
		in_b = '0;
		s_en = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_reset_idle();
		test_reg_reg();
		test_word_forms();
		test_wide_shifts();
		test_illegal();
		test_pipeline();
		$display("Errors: %0d value mismatches, %0d timeouts", err_count, timeout_count);
		if ((err_count == 0) && (timeout_count == 0))
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
